// File: src/mips_ctrl_pkg.sv
package mips_ctrl_pkg;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_R_TYPE = 6'b000000,
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_ADDI   = 6'b001000,
        OP_SLTI   = 6'b001010,
        OP_ANDI   = 6'b001100,
        OP_ORI    = 6'b001101,
        OP_LW     = 6'b100011,
        OP_SW     = 6'b101011
    } opcode_t;

    // Function field of R-type, instr[5:0]
    typedef enum logic [5:0] {
        FN_JR  = 6'b001000,
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_OR  = 6'b100101,
        FN_SLT = 6'b101010
    } funct_t;

    typedef enum logic [3:0] {
        CLS_R_ALU,
        CLS_I_ALU,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_JUMP,
        CLS_JUMP_LINK,
        CLS_JUMP_REG,
        CLS_ILLEGAL
    } instr_class_t;

    typedef enum logic [4:0] {
        S_RESET_START,
        S_FETCH,
        S_DECODE,
        S_R_EXEC,
        S_R_WB,
        S_I_EXEC,
        S_I_WB,
        S_BRANCH,
        S_MEM_ADDR,
        S_LOAD_MEM,
        S_LOAD_WB,
        S_STORE_MEM,
        S_JUMP,
        S_JUMP_LINK,
        S_JUMP_REG,
        S_ILLEGAL_EXC,
        S_OVERFLOW_EXC
    } state_t;

    // Encodings as seen by the ALU
    typedef enum logic [2:0] {
        ALU_NONE = 3'b000,
        ALU_ADD  = 3'b001,
        ALU_SUB  = 3'b010,
        ALU_AND  = 3'b011,
        ALU_OR   = 3'b100,
        ALU_SLT  = 3'b101
    } alu_op_t;

    typedef enum logic {ALU_A_PC = 1'b0, ALU_A_REG = 1'b1} alu_src_a_t;

    typedef enum logic [1:0] {
        ALU_B_REG         = 2'b00,
        ALU_B_FOUR        = 2'b01,
        ALU_B_IMM         = 2'b10,
        ALU_B_IMM_SHIFTED = 2'b11
    } alu_src_b_t;

    typedef enum logic [1:0] {
        PC_ALU_RESULT = 2'b00, // Straight from the ALU, PC + 4
        PC_ALU_OUT    = 2'b01, // Target latched in ALUOut
        PC_REG_A      = 2'b10,
        PC_EXC_VECTOR = 2'b11
    } pc_src_t;

    typedef enum logic [1:0] {DATA_ALU_OUT = 2'b00, DATA_MDR = 2'b01, DATA_PC = 2'b10} data_src_t;

    typedef enum logic [1:0] {DST_RT = 2'b00, DST_RD = 2'b01, DST_R31 = 2'b11} reg_dst_t;

    typedef enum logic {CAUSE_OVERFLOW = 1'b0, CAUSE_ILLEGAL = 1'b1} cause_t;

endpackage

// File: src/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  mips_ctrl_pkg::opcode_t      opcode,
    input  mips_ctrl_pkg::funct_t       funct,
    output mips_ctrl_pkg::instr_class_t instr_class,
    output mips_ctrl_pkg::alu_op_t      alu_op,
    output logic                        trap_ovf,
    output logic                        branch_ne
);

    always_comb begin
        instr_class = mips_ctrl_pkg::CLS_ILLEGAL; // Anything not listed below
        alu_op      = mips_ctrl_pkg::ALU_NONE;
        trap_ovf    = 1'b0;
        branch_ne   = 1'b0;

        case (opcode)
            mips_ctrl_pkg::OP_R_TYPE: begin
                instr_class = mips_ctrl_pkg::CLS_R_ALU;
                case (funct)
                    mips_ctrl_pkg::FN_ADD: begin
                        alu_op   = mips_ctrl_pkg::ALU_ADD;
                        trap_ovf = 1'b1;
                    end
                    mips_ctrl_pkg::FN_SUB: begin
                        alu_op   = mips_ctrl_pkg::ALU_SUB;
                        trap_ovf = 1'b1;
                    end
                    mips_ctrl_pkg::FN_AND: alu_op = mips_ctrl_pkg::ALU_AND;
                    mips_ctrl_pkg::FN_OR:  alu_op = mips_ctrl_pkg::ALU_OR;
                    mips_ctrl_pkg::FN_SLT: alu_op = mips_ctrl_pkg::ALU_SLT;
                    mips_ctrl_pkg::FN_JR:  instr_class = mips_ctrl_pkg::CLS_JUMP_REG;
                    default:               instr_class = mips_ctrl_pkg::CLS_ILLEGAL;
                endcase
            end

            // Immediate arithmetic never traps
            mips_ctrl_pkg::OP_ADDI: begin
                instr_class = mips_ctrl_pkg::CLS_I_ALU;
                alu_op      = mips_ctrl_pkg::ALU_ADD;
            end
            mips_ctrl_pkg::OP_ANDI: begin
                instr_class = mips_ctrl_pkg::CLS_I_ALU;
                alu_op      = mips_ctrl_pkg::ALU_AND;
            end
            mips_ctrl_pkg::OP_ORI: begin
                instr_class = mips_ctrl_pkg::CLS_I_ALU;
                alu_op      = mips_ctrl_pkg::ALU_OR;
            end
            mips_ctrl_pkg::OP_SLTI: begin
                instr_class = mips_ctrl_pkg::CLS_I_ALU;
                alu_op      = mips_ctrl_pkg::ALU_SLT;
            end

            mips_ctrl_pkg::OP_BEQ, mips_ctrl_pkg::OP_BNE: begin
                instr_class = mips_ctrl_pkg::CLS_BRANCH;
                alu_op      = mips_ctrl_pkg::ALU_SUB; // Compare A and B
                branch_ne   = (opcode == mips_ctrl_pkg::OP_BNE);
            end

            mips_ctrl_pkg::OP_LW:  instr_class = mips_ctrl_pkg::CLS_LOAD;
            mips_ctrl_pkg::OP_SW:  instr_class = mips_ctrl_pkg::CLS_STORE;
            mips_ctrl_pkg::OP_J:   instr_class = mips_ctrl_pkg::CLS_JUMP;
            mips_ctrl_pkg::OP_JAL: instr_class = mips_ctrl_pkg::CLS_JUMP_LINK;
            default:               instr_class = mips_ctrl_pkg::CLS_ILLEGAL;
        endcase
    end

endmodule

// File: src/ctrl_sequencer.sv
`timescale 1ns/1ps

module ctrl_sequencer (
    input  logic                        clk,
    input  logic                        reset,
    input  mips_ctrl_pkg::instr_class_t instr_class,
    input  logic                        trap_ovf,
    input  logic                        overflow,
    output mips_ctrl_pkg::state_t       state
);

    mips_ctrl_pkg::state_t state_next;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= mips_ctrl_pkg::S_RESET_START;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = mips_ctrl_pkg::S_FETCH; // Terminal states fall back here

        case (state)
            mips_ctrl_pkg::S_RESET_START: state_next = mips_ctrl_pkg::S_FETCH;
            mips_ctrl_pkg::S_FETCH:       state_next = mips_ctrl_pkg::S_DECODE;

            mips_ctrl_pkg::S_DECODE: begin
                case (instr_class)
                    mips_ctrl_pkg::CLS_R_ALU:     state_next = mips_ctrl_pkg::S_R_EXEC;
                    mips_ctrl_pkg::CLS_I_ALU:     state_next = mips_ctrl_pkg::S_I_EXEC;
                    mips_ctrl_pkg::CLS_BRANCH:    state_next = mips_ctrl_pkg::S_BRANCH;
                    mips_ctrl_pkg::CLS_LOAD,
                    mips_ctrl_pkg::CLS_STORE:     state_next = mips_ctrl_pkg::S_MEM_ADDR;
                    mips_ctrl_pkg::CLS_JUMP:      state_next = mips_ctrl_pkg::S_JUMP;
                    mips_ctrl_pkg::CLS_JUMP_LINK: state_next = mips_ctrl_pkg::S_JUMP_LINK;
                    mips_ctrl_pkg::CLS_JUMP_REG:  state_next = mips_ctrl_pkg::S_JUMP_REG;
                    default:                      state_next = mips_ctrl_pkg::S_ILLEGAL_EXC;
                endcase
            end

            // Only ADD and SUB may trap, AND/OR/SLT ignore the flag
            mips_ctrl_pkg::S_R_EXEC: begin
                if (trap_ovf && overflow) begin
                    state_next = mips_ctrl_pkg::S_OVERFLOW_EXC;
                end else begin
                    state_next = mips_ctrl_pkg::S_R_WB;
                end
            end

            mips_ctrl_pkg::S_I_EXEC: state_next = mips_ctrl_pkg::S_I_WB;

            mips_ctrl_pkg::S_MEM_ADDR: begin
                if (instr_class == mips_ctrl_pkg::CLS_LOAD) begin
                    state_next = mips_ctrl_pkg::S_LOAD_MEM;
                end else begin
                    state_next = mips_ctrl_pkg::S_STORE_MEM;
                end
            end

            mips_ctrl_pkg::S_LOAD_MEM: state_next = mips_ctrl_pkg::S_LOAD_WB;

            // R_WB, I_WB, BRANCH, LOAD_WB, STORE_MEM, jumps and exceptions
            default: state_next = mips_ctrl_pkg::S_FETCH;
        endcase
    end

endmodule

// File: src/ctrl_signal_gen.sv
`timescale 1ns/1ps

module ctrl_signal_gen (
    input  mips_ctrl_pkg::state_t     state,
    input  mips_ctrl_pkg::alu_op_t    alu_op_in,
    input  logic                      branch_ne,
    input  logic                      zero,
    output logic                      iord,
    output logic                      mem_wr,
    output logic                      ir_wr,
    output logic                      reg_wr,
    output logic                      wr_a,
    output logic                      wr_b,
    output logic                      alu_out_wr,
    output logic                      pc_wr,
    output logic                      epc_wr,
    output logic                      reset_out,
    output mips_ctrl_pkg::cause_t     cause,
    output mips_ctrl_pkg::reg_dst_t   reg_dst,
    output mips_ctrl_pkg::alu_src_a_t alu_src_a,
    output mips_ctrl_pkg::alu_src_b_t alu_src_b,
    output mips_ctrl_pkg::alu_op_t    alu_op,
    output mips_ctrl_pkg::pc_src_t    pc_src,
    output mips_ctrl_pkg::data_src_t  data_src
);

    always_comb begin
        // Neutral values, all enables off
        iord       = 1'b0;
        mem_wr     = 1'b0;
        ir_wr      = 1'b0;
        reg_wr     = 1'b0;
        wr_a       = 1'b0;
        wr_b       = 1'b0;
        alu_out_wr = 1'b0;
        pc_wr      = 1'b0;
        epc_wr     = 1'b0;
        reset_out  = 1'b0;
        cause      = mips_ctrl_pkg::CAUSE_OVERFLOW;
        reg_dst    = mips_ctrl_pkg::DST_RT;
        alu_src_a  = mips_ctrl_pkg::ALU_A_PC;
        alu_src_b  = mips_ctrl_pkg::ALU_B_REG;
        alu_op     = mips_ctrl_pkg::ALU_NONE;
        pc_src     = mips_ctrl_pkg::PC_ALU_RESULT;
        data_src   = mips_ctrl_pkg::DATA_ALU_OUT;

        case (state)
            mips_ctrl_pkg::S_RESET_START: reset_out = 1'b1;

            // IR <= Mem[PC], PC <= PC + 4
            mips_ctrl_pkg::S_FETCH: begin
                alu_src_b  = mips_ctrl_pkg::ALU_B_FOUR;
                alu_op     = mips_ctrl_pkg::ALU_ADD;
                alu_out_wr = 1'b1;
                ir_wr      = 1'b1;
                pc_wr      = 1'b1;
            end

            // Branch target computed speculatively while A and B load
            mips_ctrl_pkg::S_DECODE: begin
                wr_a       = 1'b1;
                wr_b       = 1'b1;
                alu_src_b  = mips_ctrl_pkg::ALU_B_IMM_SHIFTED;
                alu_op     = mips_ctrl_pkg::ALU_ADD;
                alu_out_wr = 1'b1;
            end

            mips_ctrl_pkg::S_R_EXEC: begin
                alu_src_a  = mips_ctrl_pkg::ALU_A_REG;
                alu_op     = alu_op_in;
                alu_out_wr = 1'b1;
            end
            mips_ctrl_pkg::S_R_WB: begin
                reg_dst = mips_ctrl_pkg::DST_RD;
                reg_wr  = 1'b1;
            end

            mips_ctrl_pkg::S_I_EXEC: begin
                alu_src_a  = mips_ctrl_pkg::ALU_A_REG;
                alu_src_b  = mips_ctrl_pkg::ALU_B_IMM;
                alu_op     = alu_op_in;
                alu_out_wr = 1'b1;
            end
            mips_ctrl_pkg::S_I_WB: reg_wr = 1'b1; // rt <= ALUOut

            // ALUOut still holds the target, so it is not overwritten here
            mips_ctrl_pkg::S_BRANCH: begin
                alu_src_a = mips_ctrl_pkg::ALU_A_REG;
                alu_op    = alu_op_in;
                pc_src    = mips_ctrl_pkg::PC_ALU_OUT;
                pc_wr     = branch_ne ? ~zero : zero;
            end

            mips_ctrl_pkg::S_MEM_ADDR: begin
                alu_src_a  = mips_ctrl_pkg::ALU_A_REG;
                alu_src_b  = mips_ctrl_pkg::ALU_B_IMM;
                alu_op     = mips_ctrl_pkg::ALU_ADD;
                alu_out_wr = 1'b1;
            end
            mips_ctrl_pkg::S_LOAD_MEM: iord = 1'b1; // MDR <= Mem[ALUOut]
            mips_ctrl_pkg::S_LOAD_WB: begin
                data_src = mips_ctrl_pkg::DATA_MDR;
                reg_wr   = 1'b1;
            end
            mips_ctrl_pkg::S_STORE_MEM: begin
                iord   = 1'b1;
                mem_wr = 1'b1;
            end

            mips_ctrl_pkg::S_JUMP: begin
                pc_src = mips_ctrl_pkg::PC_ALU_OUT;
                pc_wr  = 1'b1;
            end
            mips_ctrl_pkg::S_JUMP_LINK: begin
                data_src = mips_ctrl_pkg::DATA_PC; // Return address, PC already advanced
                reg_dst  = mips_ctrl_pkg::DST_R31;
                reg_wr   = 1'b1;
                pc_src   = mips_ctrl_pkg::PC_ALU_OUT;
                pc_wr    = 1'b1;
            end
            mips_ctrl_pkg::S_JUMP_REG: begin
                pc_src = mips_ctrl_pkg::PC_REG_A;
                pc_wr  = 1'b1;
            end

            mips_ctrl_pkg::S_ILLEGAL_EXC: begin
                epc_wr = 1'b1;
                cause  = mips_ctrl_pkg::CAUSE_ILLEGAL;
                pc_src = mips_ctrl_pkg::PC_EXC_VECTOR;
                pc_wr  = 1'b1;
            end
            mips_ctrl_pkg::S_OVERFLOW_EXC: begin
                epc_wr = 1'b1;
                cause  = mips_ctrl_pkg::CAUSE_OVERFLOW;
                pc_src = mips_ctrl_pkg::PC_EXC_VECTOR;
                pc_wr  = 1'b1;
            end

            default: ;
        endcase
    end

endmodule

// File: src/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  mips_ctrl_pkg::opcode_t    opcode,   // From IR, valid DECODE to next FETCH
    input  mips_ctrl_pkg::funct_t     funct,
    input  logic                      overflow,
    input  logic                      zero,
    output logic                      iord,
    output logic                      mem_wr,
    output logic                      ir_wr,
    output logic                      reg_wr,
    output logic                      wr_a,
    output logic                      wr_b,
    output logic                      alu_out_wr,
    output logic                      pc_wr,
    output logic                      epc_wr,
    output logic                      reset_out,
    output mips_ctrl_pkg::cause_t     cause,
    output mips_ctrl_pkg::reg_dst_t   reg_dst,
    output mips_ctrl_pkg::alu_src_a_t alu_src_a,
    output mips_ctrl_pkg::alu_src_b_t alu_src_b,
    output mips_ctrl_pkg::alu_op_t    alu_op,
    output mips_ctrl_pkg::pc_src_t    pc_src,
    output mips_ctrl_pkg::data_src_t  data_src
);

    mips_ctrl_pkg::instr_class_t instr_class;
    mips_ctrl_pkg::alu_op_t      dec_alu_op;
    mips_ctrl_pkg::state_t       state;
    logic                        trap_ovf;
    logic                        branch_ne;

    instr_decoder decoder_inst (
        .opcode      (opcode),
        .funct       (funct),
        .instr_class (instr_class),
        .alu_op      (dec_alu_op),
        .trap_ovf    (trap_ovf),
        .branch_ne   (branch_ne)
    );

    ctrl_sequencer sequencer_inst (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .trap_ovf    (trap_ovf),
        .overflow    (overflow),
        .state       (state)
    );

    // Moore outputs apart from the branch decision
    ctrl_signal_gen signal_gen_inst (
        .state      (state),
        .alu_op_in  (dec_alu_op),
        .branch_ne  (branch_ne),
        .zero       (zero),
        .iord       (iord),
        .mem_wr     (mem_wr),
        .ir_wr      (ir_wr),
        .reg_wr     (reg_wr),
        .wr_a       (wr_a),
        .wr_b       (wr_b),
        .alu_out_wr (alu_out_wr),
        .pc_wr      (pc_wr),
        .epc_wr     (epc_wr),
        .reset_out  (reset_out),
        .cause      (cause),
        .reg_dst    (reg_dst),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .alu_op     (alu_op),
        .pc_src     (pc_src),
        .data_src   (data_src)
    );

endmodule

// File: tb/control_unit_properties.sv
`timescale 1ns/1ps

module control_unit_properties (
    input logic                   clk,
    input logic                   reset,
    input logic                   ir_wr,
    input logic                   reg_wr,
    input logic                   mem_wr,
    input logic                   epc_wr,
    input mips_ctrl_pkg::pc_src_t pc_src
);

    // FETCH never writes the register file
    fetch_without_reg_write: assert property (
        @(posedge clk) disable iff (reset) !(ir_wr && reg_wr)
    ) else $error("ir_wr and reg_wr are high in the same cycle");

    // Exceptions always redirect to the vector
    epc_with_exc_vector: assert property (
        @(posedge clk) disable iff (reset) epc_wr |-> (pc_src == mips_ctrl_pkg::PC_EXC_VECTOR)
    ) else $error("epc_wr is high while pc_src is not the exception vector");

    mem_wr_single_cycle: assert property (
        @(posedge clk) disable iff (reset) mem_wr |=> !mem_wr
    ) else $error("mem_wr stays high for two consecutive cycles");

endmodule

// File: tb/control_unit_tb.sv
`timescale 1ns/1ps

module control_unit_tb;

    typedef struct {
        string                    name;
        logic [5:0]               opcode;
        logic [5:0]               funct;       // Raw fields, so unknown codes fit
        logic                     overflow;
        logic                     zero;
        int                       cycles;      // ir_wr pulse to the next one
        mips_ctrl_pkg::alu_op_t   exec_op;     // First cycle after DECODE
        int                       reg_writes;
        mips_ctrl_pkg::reg_dst_t  wb_dst;
        mips_ctrl_pkg::data_src_t wb_src;
        int                       mem_writes;
        logic                     exec_pc_wr;
        mips_ctrl_pkg::pc_src_t   exec_pc_src;
        logic                     epc_write;
        mips_ctrl_pkg::cause_t    epc_cause;
    } test_row_t;

    logic                      clk;
    logic                      reset;
    mips_ctrl_pkg::opcode_t    opcode;
    mips_ctrl_pkg::funct_t     funct;
    logic                      overflow;
    logic                      zero;
    logic                      iord;
    logic                      mem_wr;
    logic                      ir_wr;
    logic                      reg_wr;
    logic                      wr_a;
    logic                      wr_b;
    logic                      alu_out_wr;
    logic                      pc_wr;
    logic                      epc_wr;
    logic                      reset_out;
    mips_ctrl_pkg::cause_t     cause;
    mips_ctrl_pkg::reg_dst_t   reg_dst;
    mips_ctrl_pkg::alu_src_a_t alu_src_a;
    mips_ctrl_pkg::alu_src_b_t alu_src_b;
    mips_ctrl_pkg::alu_op_t    alu_op;
    mips_ctrl_pkg::pc_src_t    pc_src;
    mips_ctrl_pkg::data_src_t  data_src;
    logic [7:0]                enables;

    test_row_t rows[$];
    int        value_errors = 0;
    int        other_errors = 0;

    assign enables = {mem_wr, ir_wr, reg_wr, wr_a, wr_b, alu_out_wr, pc_wr, epc_wr};

    control_unit control_unit_inst (
        .clk        (clk),
        .reset      (reset),
        .opcode     (opcode),
        .funct      (funct),
        .overflow   (overflow),
        .zero       (zero),
        .iord       (iord),
        .mem_wr     (mem_wr),
        .ir_wr      (ir_wr),
        .reg_wr     (reg_wr),
        .wr_a       (wr_a),
        .wr_b       (wr_b),
        .alu_out_wr (alu_out_wr),
        .pc_wr      (pc_wr),
        .epc_wr     (epc_wr),
        .reset_out  (reset_out),
        .cause      (cause),
        .reg_dst    (reg_dst),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .alu_op     (alu_op),
        .pc_src     (pc_src),
        .data_src   (data_src)
    );

    bind control_unit control_unit_properties properties_inst (
        .clk    (clk),
        .reset  (reset),
        .ir_wr  (ir_wr),
        .reg_wr (reg_wr),
        .mem_wr (mem_wr),
        .epc_wr (epc_wr),
        .pc_src (pc_src)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string signal, input int expected, input int actual);
        value_errors++;
        $display("error at %0d ns: %s expected %0d, got %0d", $time, signal, expected, actual);
    endtask

    function automatic void add_row(
        input string name, input logic [5:0] op, input logic [5:0] fn, input logic ovf,
        input logic zr, input int cycles, input mips_ctrl_pkg::alu_op_t exec_op,
        input int reg_writes, input mips_ctrl_pkg::reg_dst_t dst,
        input mips_ctrl_pkg::data_src_t src, input int mem_writes, input logic exec_pc_wr,
        input mips_ctrl_pkg::pc_src_t exec_pc_src, input logic epc,
        input mips_ctrl_pkg::cause_t epc_cause
    );
        test_row_t row;
        row = '{name, op, fn, ovf, zr, cycles, exec_op, reg_writes, dst, src,
                mem_writes, exec_pc_wr, exec_pc_src, epc, epc_cause};
        rows.push_back(row);
    endfunction

    // Name, opcode, funct, overflow, zero, cycles, then expected outputs
    task automatic build_table();
        add_row("add", mips_ctrl_pkg::OP_R_TYPE, mips_ctrl_pkg::FN_ADD, 1'b0, 1'b0, 4,
                mips_ctrl_pkg::ALU_ADD, 1, mips_ctrl_pkg::DST_RD, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_RESULT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("sub", mips_ctrl_pkg::OP_R_TYPE, mips_ctrl_pkg::FN_SUB, 1'b0, 1'b0, 4,
                mips_ctrl_pkg::ALU_SUB, 1, mips_ctrl_pkg::DST_RD, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_RESULT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("and", mips_ctrl_pkg::OP_R_TYPE, mips_ctrl_pkg::FN_AND, 1'b0, 1'b0, 4,
                mips_ctrl_pkg::ALU_AND, 1, mips_ctrl_pkg::DST_RD, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_RESULT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("or", mips_ctrl_pkg::OP_R_TYPE, mips_ctrl_pkg::FN_OR, 1'b0, 1'b0, 4,
                mips_ctrl_pkg::ALU_OR, 1, mips_ctrl_pkg::DST_RD, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_RESULT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("slt", mips_ctrl_pkg::OP_R_TYPE, mips_ctrl_pkg::FN_SLT, 1'b0, 1'b0, 4,
                mips_ctrl_pkg::ALU_SLT, 1, mips_ctrl_pkg::DST_RD, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_RESULT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("addi", mips_ctrl_pkg::OP_ADDI, 6'h00, 1'b0, 1'b0, 4,
                mips_ctrl_pkg::ALU_ADD, 1, mips_ctrl_pkg::DST_RT, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_RESULT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("andi", mips_ctrl_pkg::OP_ANDI, 6'h00, 1'b0, 1'b0, 4,
                mips_ctrl_pkg::ALU_AND, 1, mips_ctrl_pkg::DST_RT, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_RESULT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("ori", mips_ctrl_pkg::OP_ORI, 6'h00, 1'b0, 1'b0, 4,
                mips_ctrl_pkg::ALU_OR, 1, mips_ctrl_pkg::DST_RT, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_RESULT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("slti", mips_ctrl_pkg::OP_SLTI, 6'h00, 1'b0, 1'b0, 4,
                mips_ctrl_pkg::ALU_SLT, 1, mips_ctrl_pkg::DST_RT, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_RESULT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        // Overflow traps only on ADD and SUB
        add_row("add ovf", mips_ctrl_pkg::OP_R_TYPE, mips_ctrl_pkg::FN_ADD, 1'b1, 1'b0, 4,
                mips_ctrl_pkg::ALU_ADD, 0, mips_ctrl_pkg::DST_RD, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_RESULT, 1'b1, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("sub ovf", mips_ctrl_pkg::OP_R_TYPE, mips_ctrl_pkg::FN_SUB, 1'b1, 1'b0, 4,
                mips_ctrl_pkg::ALU_SUB, 0, mips_ctrl_pkg::DST_RD, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_RESULT, 1'b1, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("and ovf", mips_ctrl_pkg::OP_R_TYPE, mips_ctrl_pkg::FN_AND, 1'b1, 1'b0, 4,
                mips_ctrl_pkg::ALU_AND, 1, mips_ctrl_pkg::DST_RD, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_RESULT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("lw", mips_ctrl_pkg::OP_LW, 6'h00, 1'b0, 1'b0, 5,
                mips_ctrl_pkg::ALU_ADD, 1, mips_ctrl_pkg::DST_RT, mips_ctrl_pkg::DATA_MDR,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_RESULT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("sw", mips_ctrl_pkg::OP_SW, 6'h00, 1'b0, 1'b0, 4,
                mips_ctrl_pkg::ALU_ADD, 0, mips_ctrl_pkg::DST_RT, mips_ctrl_pkg::DATA_ALU_OUT,
                1, 1'b0, mips_ctrl_pkg::PC_ALU_RESULT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("beq taken", mips_ctrl_pkg::OP_BEQ, 6'h00, 1'b0, 1'b1, 3,
                mips_ctrl_pkg::ALU_SUB, 0, mips_ctrl_pkg::DST_RT, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b1, mips_ctrl_pkg::PC_ALU_OUT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("beq not taken", mips_ctrl_pkg::OP_BEQ, 6'h00, 1'b0, 1'b0, 3,
                mips_ctrl_pkg::ALU_SUB, 0, mips_ctrl_pkg::DST_RT, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_OUT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("bne taken", mips_ctrl_pkg::OP_BNE, 6'h00, 1'b0, 1'b0, 3,
                mips_ctrl_pkg::ALU_SUB, 0, mips_ctrl_pkg::DST_RT, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b1, mips_ctrl_pkg::PC_ALU_OUT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("bne not taken", mips_ctrl_pkg::OP_BNE, 6'h00, 1'b0, 1'b1, 3,
                mips_ctrl_pkg::ALU_SUB, 0, mips_ctrl_pkg::DST_RT, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b0, mips_ctrl_pkg::PC_ALU_OUT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("j", mips_ctrl_pkg::OP_J, 6'h00, 1'b0, 1'b0, 3,
                mips_ctrl_pkg::ALU_NONE, 0, mips_ctrl_pkg::DST_RT, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b1, mips_ctrl_pkg::PC_ALU_OUT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("jal", mips_ctrl_pkg::OP_JAL, 6'h00, 1'b0, 1'b0, 3,
                mips_ctrl_pkg::ALU_NONE, 1, mips_ctrl_pkg::DST_R31, mips_ctrl_pkg::DATA_PC,
                0, 1'b1, mips_ctrl_pkg::PC_ALU_OUT, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("jr", mips_ctrl_pkg::OP_R_TYPE, mips_ctrl_pkg::FN_JR, 1'b0, 1'b0, 3,
                mips_ctrl_pkg::ALU_NONE, 0, mips_ctrl_pkg::DST_RT, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b1, mips_ctrl_pkg::PC_REG_A, 1'b0, mips_ctrl_pkg::CAUSE_OVERFLOW);
        add_row("bad opcode", 6'h3f, 6'h00, 1'b0, 1'b0, 3,
                mips_ctrl_pkg::ALU_NONE, 0, mips_ctrl_pkg::DST_RT, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b1, mips_ctrl_pkg::PC_EXC_VECTOR, 1'b1, mips_ctrl_pkg::CAUSE_ILLEGAL);
        add_row("bad funct", mips_ctrl_pkg::OP_R_TYPE, 6'h01, 1'b0, 1'b0, 3,
                mips_ctrl_pkg::ALU_NONE, 0, mips_ctrl_pkg::DST_RT, mips_ctrl_pkg::DATA_ALU_OUT,
                0, 1'b1, mips_ctrl_pkg::PC_EXC_VECTOR, 1'b1, mips_ctrl_pkg::CAUSE_ILLEGAL);
    endtask

    // Runs from the cycle after FETCH up to the next FETCH
    task automatic apply_row(input test_row_t row);
        int cycles;
        int reg_writes;
        int mem_writes;
        int epc_writes;
        cycles     = 0;
        reg_writes = 0;
        mem_writes = 0;
        epc_writes = 0;
        do begin
            @(posedge clk);
            #2;
            opcode   = mips_ctrl_pkg::opcode_t'(row.opcode);
            funct    = mips_ctrl_pkg::funct_t'(row.funct);
            overflow = row.overflow;
            zero     = row.zero;
            @(negedge clk); // Outputs settled mid-cycle
            cycles++;
            if (cycles == 1) begin // DECODE loads A and B
                if (wr_a != 1'b1)
                    report_mismatch({row.name, " wr_a"}, 1, int'(wr_a));
                if (wr_b != 1'b1)
                    report_mismatch({row.name, " wr_b"}, 1, int'(wr_b));
                if (alu_src_b != mips_ctrl_pkg::ALU_B_IMM_SHIFTED)
                    report_mismatch({row.name, " alu_src_b"},
                                    int'(mips_ctrl_pkg::ALU_B_IMM_SHIFTED), int'(alu_src_b));
            end
            if (cycles == 2) begin
                if (alu_op != row.exec_op)
                    report_mismatch({row.name, " alu_op"}, int'(row.exec_op), int'(alu_op));
                if (pc_wr != row.exec_pc_wr)
                    report_mismatch({row.name, " pc_wr"}, int'(row.exec_pc_wr), int'(pc_wr));
                if (pc_src != row.exec_pc_src)
                    report_mismatch({row.name, " pc_src"}, int'(row.exec_pc_src), int'(pc_src));
            end
            if (ir_wr) begin // Next FETCH, PC plus four
                if (alu_src_a != mips_ctrl_pkg::ALU_A_PC)
                    report_mismatch({row.name, " fetch alu_src_a"},
                                    int'(mips_ctrl_pkg::ALU_A_PC), int'(alu_src_a));
                if (alu_src_b != mips_ctrl_pkg::ALU_B_FOUR)
                    report_mismatch({row.name, " fetch alu_src_b"},
                                    int'(mips_ctrl_pkg::ALU_B_FOUR), int'(alu_src_b));
                if (iord != 1'b0)
                    report_mismatch({row.name, " fetch iord"}, 0, int'(iord));
                if (pc_wr != 1'b1)
                    report_mismatch({row.name, " fetch pc_wr"}, 1, int'(pc_wr));
            end
            if (reg_wr) begin
                reg_writes++;
                if (reg_dst != row.wb_dst)
                    report_mismatch({row.name, " reg_dst"}, int'(row.wb_dst), int'(reg_dst));
                if (data_src != row.wb_src)
                    report_mismatch({row.name, " data_src"}, int'(row.wb_src), int'(data_src));
            end
            if (mem_wr) begin
                mem_writes++;
                if (iord != 1'b1)
                    report_mismatch({row.name, " iord"}, 1, int'(iord));
            end
            if (epc_wr) begin
                epc_writes++;
                if (cause != row.epc_cause)
                    report_mismatch({row.name, " cause"}, int'(row.epc_cause), int'(cause));
            end
        end while (!ir_wr && cycles < 8);

        if (!ir_wr) begin
            other_errors++;
            $display("Instruction %s never returned to FETCH within 8 cycles", row.name);
        end
        if (cycles != row.cycles)
            report_mismatch({row.name, " cycles"}, row.cycles, cycles);
        if (reg_writes != row.reg_writes)
            report_mismatch({row.name, " reg_wr count"}, row.reg_writes, reg_writes);
        if (mem_writes != row.mem_writes)
            report_mismatch({row.name, " mem_wr count"}, row.mem_writes, mem_writes);
        if (epc_writes != int'(row.epc_write))
            report_mismatch({row.name, " epc_wr count"}, int'(row.epc_write), epc_writes);
    endtask

    initial begin
        reset    = 1'b1;
        opcode   = mips_ctrl_pkg::OP_R_TYPE;
        funct    = mips_ctrl_pkg::FN_ADD;
        overflow = 1'b0;
        zero     = 1'b0;
        build_table();

        repeat (9) @(posedge clk);
        @(negedge clk);
        if (enables != 8'b0)
            report_mismatch("enables in reset", 0, int'(enables));
        @(posedge clk);
        #2;
        reset = 1'b0; // Released after 10 edges

        @(negedge clk); // RESET_START
        if (reset_out != 1'b1)
            report_mismatch("reset_out", 1, int'(reset_out));
        if (enables != 8'b0)
            report_mismatch("enables in RESET_START", 0, int'(enables));
        @(negedge clk); // First FETCH
        if (reset_out != 1'b0)
            report_mismatch("reset_out", 0, int'(reset_out));
        if (ir_wr != 1'b1)
            report_mismatch("ir_wr", 1, int'(ir_wr));

        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
        end

        $display("Ran %0d instructions: %0d value errors, %0d other failures",
                 rows.size(), value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Eight cycles per row leaves margin over the longest instruction
    initial begin
        int limit;
        #1;
        limit = rows.size() * 8 + 40;
        repeat (limit) @(posedge clk);
        other_errors++;
        $display("Watchdog expired after %0d cycles, the run did not complete", limit);
        $display("Errors so far: %0d value errors, %0d other failures",
                 value_errors, other_errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: compile.f
src/mips_ctrl_pkg.sv
src/instr_decoder.sv
src/ctrl_sequencer.sv
src/ctrl_signal_gen.sv
src/control_unit.sv
tb/control_unit_properties.sv
tb/control_unit_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module control_unit_tb -f compile.f \
    -o control_unit_sim || { echo "Build failed"; exit 1; }
./obj_dir/control_unit_sim > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0
